//--- source/dma_types_pkg.sv
/* shared widths and device codes for the zdma engine
   DRAM is word addressed; one burst moves len+1 words */
package dma_types_pkg;

	typedef logic [20:0] dram_addr_t;   // DRAM word address
	typedef logic [15:0] dma_word_t;    // one transfer word
	typedef logic [7:0]  sd_byte_t;     // SD data path is byte wide
	typedef logic [7:0]  burst_len_t;   // programmed length, words minus one
	typedef logic [8:0]  burst_ctr_t;   // remaining count, msb set means done
	typedef logic [2:0]  dev_sel_t;     // target device code

	// host register port
	typedef logic [4:0]  axil_addr_t;   // byte offset into the register map
	typedef logic [31:0] axil_data_t;

	// device codes as written to CTRL
	localparam dev_sel_t DEV_RAM = 3'd1; // DRAM to DRAM copy
	localparam dev_sel_t DEV_SD  = 3'd2; // 8 bit card port, two strobes per word
	localparam dev_sel_t DEV_IDE = 3'd3; // 16 bit port, other codes land here too

endpackage

//--- source/dma_regs_pkg.sv
/* register map of the zdma host port
   offsets are byte offsets, only word aligned ones are decoded */
package dma_regs_pkg;

	// offsets
	localparam logic [4:0] REG_SADDR  = 5'h00; // source word address, bits 20..0
	localparam logic [4:0] REG_DADDR  = 5'h04; // destination word address
	localparam logic [4:0] REG_LEN    = 5'h08; // words minus one, bits 7..0
	localparam logic [4:0] REG_CTRL   = 5'h0C; // write launches a burst
	localparam logic [4:0] REG_STATUS = 5'h10; // read only

	// CTRL fields
	localparam int DEV_LSB  = 0;    // device code
	localparam int DEV_MSB  = 2;
	localparam int CTRL_WNR = 7;    // 1: DRAM to device, 0: device to DRAM

	// STATUS fields, bits 7..0 are the remaining words minus one
	localparam int STAT_ACT = 8;    // burst running

	// bus responses
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- source/dma_csr_axil.sv
/* AXI4-Lite slave for the burst setup, AW and W must arrive in the same cycle
   WSTRB is not decoded, partial writes store the whole word
   every write gets SLVERR while a burst is active and changes nothing */
`timescale 1ns/1ps

module dma_csr_axil
	import dma_types_pkg::*, dma_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// AXI4-Lite slave
	input  axil_addr_t s_awaddr,
	input  logic       s_awvalid,
	output logic       s_awready,
	input  axil_data_t s_wdata,
	input  logic [3:0] s_wstrb,     // accepted, not decoded
	input  logic       s_wvalid,
	output logic       s_wready,
	output logic [1:0] s_bresp,
	output logic       s_bvalid,
	input  logic       s_bready,
	input  axil_addr_t s_araddr,
	input  logic       s_arvalid,
	output logic       s_arready,
	output axil_data_t s_rdata,
	output logic [1:0] s_rresp,
	output logic       s_rvalid,
	input  logic       s_rready,

	// burst setup towards the engine
	output dram_addr_t saddr,
	output dram_addr_t daddr,
	output burst_len_t blen,
	output dev_sel_t   dev,
	output logic       wnr,
	output logic       launch,     // one cycle, on the accepted CTRL write
	input  logic       active,
	input  burst_len_t remaining
);

	typedef enum logic {W_IDLE, W_RESP} wr_state_t;
	typedef enum logic {R_IDLE, R_RESP} rd_state_t;

	wr_state_t  wr_state;
	rd_state_t  rd_state;
	logic       wr_hs;      // AW and W taken together
	logic       wr_ok;      // write will be stored
	dev_sel_t   wr_dev;
	logic       rd_hs;
	logic       rd_ok;
	axil_data_t rd_word;

	// write channel
	assign wr_hs     = (wr_state == W_IDLE) && s_awvalid && s_wvalid;
	assign s_awready = wr_hs;
	assign s_wready  = wr_hs;
	assign s_bvalid  = (wr_state == W_RESP);
	assign wr_dev    = s_wdata[DEV_MSB:DEV_LSB];

	always_comb
	begin
		case (s_awaddr)
			REG_SADDR, REG_DADDR, REG_LEN, REG_CTRL: wr_ok = !active; // locked while running
			default:                                  wr_ok = 1'b0;    // STATUS and holes
		endcase
	end

	// engine starts on the handshake edge, so active rises with bvalid
	assign launch = wr_hs && wr_ok && (s_awaddr == REG_CTRL);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wr_state <= W_IDLE;
		else
		begin
			case (wr_state)
				W_IDLE: if (wr_hs) wr_state <= W_RESP;
				W_RESP: if (s_bready) wr_state <= W_IDLE; // hold until taken
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// setup registers and write response
	always_ff @(posedge clk)
	begin
		if (wr_hs)
			s_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (wr_hs && wr_ok)
		begin
			case (s_awaddr)
				REG_SADDR: saddr <= s_wdata[$bits(dram_addr_t)-1:0];
				REG_DADDR: daddr <= s_wdata[$bits(dram_addr_t)-1:0];
				REG_LEN:   blen  <= s_wdata[$bits(burst_len_t)-1:0];
				default:   ;
			endcase
		end
	end

	// burst mode, latched by launch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dev <= DEV_RAM;
			wnr <= 1'b0;
		end
		else if (launch)
		begin
			// unknown codes fold onto IDE
			dev <= (wr_dev == DEV_RAM || wr_dev == DEV_SD) ? wr_dev : DEV_IDE;
			wnr <= s_wdata[CTRL_WNR];
		end
	end

	// read channel
	assign rd_hs     = (rd_state == R_IDLE) && s_arvalid;
	assign s_arready = rd_hs;
	assign s_rvalid  = (rd_state == R_RESP);

	always_comb
	begin
		rd_word = '0;
		rd_ok   = 1'b1;
		case (s_araddr)
			REG_SADDR: rd_word[$bits(dram_addr_t)-1:0] = saddr;
			REG_DADDR: rd_word[$bits(dram_addr_t)-1:0] = daddr;
			REG_LEN:   rd_word[$bits(burst_len_t)-1:0] = blen;
			REG_CTRL:
			begin
				rd_word[DEV_MSB:DEV_LSB] = dev;
				rd_word[CTRL_WNR]        = wnr;
			end
			REG_STATUS:
			begin
				rd_word[STAT_ACT]                  = active;
				rd_word[$bits(burst_len_t)-1:0]    = remaining;
			end
			default: rd_ok = 1'b0; // hole, reads zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_state <= R_IDLE;
		else
		begin
			case (rd_state)
				R_IDLE: if (rd_hs) rd_state <= R_RESP;
				R_RESP: if (s_rready) rd_state <= R_IDLE;
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_hs)
		begin
			s_rdata <= rd_word;  // snapshot at the address handshake
			s_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

//--- source/dma_engine.sv
/* burst engine: one read phase then one write phase per word, len+1 words
   DRAM and device requests are held until their strobe
   setup inputs must stay stable while active is high */
`timescale 1ns/1ps

module dma_engine
	import dma_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// setup from the register block
	input  dram_addr_t saddr,
	input  dram_addr_t daddr,
	input  burst_len_t blen,
	input  dev_sel_t   dev,
	input  logic       wnr,        // 1: DRAM to device
	input  logic       launch,
	output logic       active,
	output burst_len_t remaining,

	// DRAM port
	output dram_addr_t dram_addr,
	output dma_word_t  dram_wrdata,
	input  dma_word_t  dram_rddata,
	output logic       dram_req,
	output logic       dram_rnw,
	input  logic       dram_next,

	// device port, through the router
	output logic       dev_req,
	output logic       dev_rnw,
	output dma_word_t  dev_wrdata,
	input  dma_word_t  dev_rddata,
	input  logic       dev_stb
);

	typedef enum logic [1:0] {IDLE, RD, WR} phase_t;

	phase_t     phase;
	burst_ctr_t ctr;        // msb is the done flag
	burst_ctr_t ctr_dec;
	dram_addr_t src_addr;
	dram_addr_t dst_addr;
	dma_word_t  data;       // word in flight
	logic       is_ram;
	logic       rd_mem;     // read phase goes to DRAM
	logic       wr_mem;     // write phase goes to DRAM
	logic       use_mem;
	logic       phase_end;

	// resource per phase
	//   RAM copy      : DRAM / DRAM
	//   wnr=1         : DRAM / device
	//   wnr=0         : device / DRAM
	assign is_ram = (dev == DEV_RAM);
	assign rd_mem = is_ram || wnr;
	assign wr_mem = is_ram || !wnr;

	always_comb
	begin
		case (phase)
			RD:      use_mem = rd_mem;
			WR:      use_mem = wr_mem;
			default: use_mem = 1'b0;
		endcase
	end

	assign dram_req    = (phase != IDLE) && use_mem;
	assign dram_rnw    = (phase == RD);
	assign dram_addr   = (phase == RD) ? src_addr : dst_addr;
	assign dram_wrdata = data;

	assign dev_req    = (phase != IDLE) && !use_mem;
	assign dev_rnw    = (phase == RD);
	assign dev_wrdata = data;

	// phase closes on the strobe of whichever side holds the request
	assign phase_end = (dram_req && dram_next) || (dev_req && dev_stb);

	assign ctr_dec   = ctr - 1'b1;
	assign active    = !ctr[8];
	assign remaining = active ? ctr[7:0] : '0; // idle reads as zero

	// phase machine and word counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase <= IDLE;
			ctr   <= {1'b1, 8'h00};  // done, nothing running
		end
		else if (launch)
		begin
			phase <= RD;
			ctr   <= {1'b0, blen};
		end
		else if (phase_end)
		begin
			if (phase == RD)
				phase <= WR;         // write follows right after the read strobe
			else
			begin
				ctr   <= ctr_dec;    // word done
				phase <= ctr_dec[8] ? IDLE : RD; // underflow ends the burst
			end
		end
	end

	// address counters, bumped per DRAM strobe
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			src_addr <= saddr;
			dst_addr <= daddr;
		end
		else if (dram_req && dram_next)
		begin
			if (dram_rnw)
				src_addr <= src_addr + 1'b1;
			else
				dst_addr <= dst_addr + 1'b1;
		end
	end

	// capture the read side, whichever port it was
	always_ff @(posedge clk)
	begin
		if ((phase == RD) && phase_end)
			data <= use_mem ? dram_rddata : dev_rddata;
	end

endmodule

//--- source/dma_dev_router.sv
/* steers the engine's device request to SD or IDE
   SD words take two byte strobes, low byte first, dev_stb only on the second */
`timescale 1ns/1ps

module dma_dev_router
	import dma_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dev_sel_t  dev,

	// engine side
	input  logic      dev_req,
	input  logic      dev_rnw,
	input  dma_word_t dev_wrdata,
	output dma_word_t dev_rddata,
	output logic      dev_stb,

	// SD card port
	output logic      sd_req,
	output logic      sd_rnw,
	output sd_byte_t  sd_wrdata,
	input  sd_byte_t  sd_rddata,
	input  logic      sd_stb,

	// IDE port
	output logic      ide_req,
	output logic      ide_rnw,
	output dma_word_t ide_wrdata,
	input  dma_word_t ide_rddata,
	input  logic      ide_stb
);

	logic     sd_sel;
	logic     ide_sel;
	logic     bsel;       // 0: low byte, 1: high byte
	sd_byte_t lo_byte;    // first byte of a read word
	logic     sd_hit;

	assign sd_sel  = (dev == DEV_SD);
	assign ide_sel = (dev == DEV_IDE);  // codes were folded at launch
	assign sd_hit  = sd_req && sd_stb;

	assign sd_req    = dev_req && sd_sel;
	assign sd_rnw    = dev_rnw;
	assign sd_wrdata = bsel ? dev_wrdata[15:8] : dev_wrdata[7:0];

	assign ide_req    = dev_req && ide_sel;
	assign ide_rnw    = dev_rnw;
	assign ide_wrdata = dev_wrdata;

	// high byte comes straight off the bus with the second strobe
	assign dev_rddata = sd_sel ? {sd_rddata, lo_byte} : ide_rddata;
	assign dev_stb    = (sd_hit && bsel) || (ide_req && ide_stb);

	// byte select, parked low whenever no request is up
	always_ff @(posedge clk)
	begin
		if (!rst_n || !dev_req)
			bsel <= 1'b0;
		else if (sd_hit)
			bsel <= !bsel;
	end

	always_ff @(posedge clk)
	begin
		if (sd_hit && !bsel && dev_rnw)
			lo_byte <= sd_rddata;   // hold until the high byte shows
	end

endmodule

//--- source/zdma_top.sv
/* zdma top: register port, burst engine and device router
   busy follows the engine's active flag */
`timescale 1ns/1ps

module zdma_top
	import dma_types_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// host AXI4-Lite
	input  axil_addr_t s_awaddr,
	input  logic       s_awvalid,
	output logic       s_awready,
	input  axil_data_t s_wdata,
	input  logic [3:0] s_wstrb,
	input  logic       s_wvalid,
	output logic       s_wready,
	output logic [1:0] s_bresp,
	output logic       s_bvalid,
	input  logic       s_bready,
	input  axil_addr_t s_araddr,
	input  logic       s_arvalid,
	output logic       s_arready,
	output axil_data_t s_rdata,
	output logic [1:0] s_rresp,
	output logic       s_rvalid,
	input  logic       s_rready,

	// DRAM
	output dram_addr_t dram_addr,
	output dma_word_t  dram_wrdata,
	input  dma_word_t  dram_rddata,
	output logic       dram_req,
	output logic       dram_rnw,
	input  logic       dram_next,

	// SD
	output logic       sd_req,
	output logic       sd_rnw,
	output sd_byte_t   sd_wrdata,
	input  sd_byte_t   sd_rddata,
	input  logic       sd_stb,

	// IDE
	output logic       ide_req,
	output logic       ide_rnw,
	output dma_word_t  ide_wrdata,
	input  dma_word_t  ide_rddata,
	input  logic       ide_stb,

	output logic       busy
);

	// setup, CSR to engine
	dram_addr_t saddr;
	dram_addr_t daddr;
	burst_len_t blen;
	dev_sel_t   dev;
	logic       wnr;
	logic       launch;
	logic       active;
	burst_len_t remaining;

	// engine to router
	logic       dev_req;
	logic       dev_rnw;
	dma_word_t  dev_wrdata;
	dma_word_t  dev_rddata;
	logic       dev_stb;

	assign busy = active;

	// port names line up one to one
	dma_csr_axil   csr_inst    (.*);
	dma_engine     engine_inst (.*);
	dma_dev_router router_inst (.*);

endmodule

//--- verif/zdma_properties.sv
/* handshake checks for zdma_top, bound to every instance of it
   fail_count is read back by the testbench at the end of the run */
`timescale 1ns/1ps

module zdma_properties
	import dma_types_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       busy,
	input logic       dram_req,
	input logic       dram_rnw,
	input logic       dram_next,
	input dram_addr_t dram_addr,
	input dma_word_t  dram_wrdata,
	input logic       sd_req,
	input logic       sd_rnw,
	input sd_byte_t   sd_wrdata,
	input logic       sd_stb,
	input logic       ide_req,
	input logic       ide_rnw,
	input dma_word_t  ide_wrdata,
	input logic       ide_stb,
	input logic       s_bvalid,
	input logic       s_bready,
	input logic [1:0] s_bresp,
	input logic       s_rvalid,
	input logic       s_rready,
	input axil_data_t s_rdata,
	input logic [1:0] s_rresp
);

	int unsigned fail_count = 0;

	// requests held until the strobe
	assert property (@(posedge clk) disable iff (!rst_n) dram_req && !dram_next |=>
		dram_req && $stable(dram_rnw) && $stable(dram_addr) && $stable(dram_wrdata))
	else
	begin
		fail_count++;
		$error("dram request dropped or changed before dram_next");
	end

	assert property (@(posedge clk) disable iff (!rst_n) sd_req && !sd_stb |=>
		sd_req && $stable(sd_rnw) && $stable(sd_wrdata))
	else
	begin
		fail_count++;
		$error("sd request dropped or changed before sd_stb");
	end

	assert property (@(posedge clk) disable iff (!rst_n) ide_req && !ide_stb |=>
		ide_req && $stable(ide_rnw) && $stable(ide_wrdata))
	else
	begin
		fail_count++;
		$error("ide request dropped or changed before ide_stb");
	end

	// responses held until ready
	assert property (@(posedge clk) disable iff (!rst_n) s_bvalid && !s_bready |=>
		s_bvalid && $stable(s_bresp))
	else
	begin
		fail_count++;
		$error("write response not held until bready");
	end

	assert property (@(posedge clk) disable iff (!rst_n) s_rvalid && !s_rready |=>
		s_rvalid && $stable(s_rdata) && $stable(s_rresp))
	else
	begin
		fail_count++;
		$error("read response not held until rready");
	end

	// idle engine touches no port
	assert property (@(posedge clk) disable iff (!rst_n) !busy |-> !dram_req && !sd_req && !ide_req)
	else
	begin
		fail_count++;
		$error("request raised while busy is low");
	end

endmodule

bind zdma_top zdma_properties props_inst (.*);

//--- verif/zdma_tb.sv
/* directed tests for zdma_top with DRAM, SD and IDE models
   the DRAM model covers 4096 words so burst addresses must stay below that */
`timescale 1ns/1ps

module zdma_tb
	import dma_types_pkg::*, dma_regs_pkg::*;
#(
	parameter int SEED = 6646
);

	// longest test is well under 1000 cycles even at the slow strobe span
	localparam int unsigned TIMEOUT_CYCLES = 20000;
	localparam int MEM_WORDS = 4096;

	logic       clk = 1'b0;
	logic       rst_n;
	axil_addr_t s_awaddr;
	logic       s_awvalid;
	logic       s_awready;
	axil_data_t s_wdata;
	logic [3:0] s_wstrb;
	logic       s_wvalid;
	logic       s_wready;
	logic [1:0] s_bresp;
	logic       s_bvalid;
	logic       s_bready;
	axil_addr_t s_araddr;
	logic       s_arvalid;
	logic       s_arready;
	axil_data_t s_rdata;
	logic [1:0] s_rresp;
	logic       s_rvalid;
	logic       s_rready;
	dram_addr_t dram_addr;
	dma_word_t  dram_wrdata;
	dma_word_t  dram_rddata = '0;
	logic       dram_req;
	logic       dram_rnw;
	logic       dram_next = 1'b0;
	logic       sd_req;
	logic       sd_rnw;
	sd_byte_t   sd_wrdata;
	sd_byte_t   sd_rddata = '0;
	logic       sd_stb = 1'b0;
	logic       ide_req;
	logic       ide_rnw;
	dma_word_t  ide_wrdata;
	dma_word_t  ide_rddata = '0;
	logic       ide_stb = 1'b0;
	logic       busy;

	int          seed = SEED;
	int unsigned delay_span = 3;   // strobe delay 1..span cycles
	int unsigned cycles = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	int unsigned dram_wait = 0;
	int unsigned sd_wait = 0;
	int unsigned ide_wait = 0;

	dma_word_t mem [0:MEM_WORDS-1];
	sd_byte_t  sd_src[$];          // bytes the card hands out
	sd_byte_t  sd_sink[$];
	dma_word_t ide_src[$];
	dma_word_t ide_sink[$];

	zdma_top zdma_top_inst (.*);

	always #10 clk = ~clk;

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, a handshake or burst never completed", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic int unsigned draw_delay();
		int r;
		r = $random(seed);
		return 1 + ($unsigned(r) % delay_span);
	endfunction

	// odd multiplier keeps the pattern unique over all 12 address bits
	function automatic dma_word_t fill_word(input int unsigned a);
		logic [31:0] p;
		p = a * 32'h9E37;
		return p[15:0] ^ 16'h3C5A;
	endfunction

	function automatic axil_data_t ctrl_word(input dev_sel_t d, input logic to_dev);
		axil_data_t w;
		w = '0;
		w[DEV_MSB:DEV_LSB] = d;
		w[CTRL_WNR]        = to_dev;   // 1 means DRAM to device
		return w;
	endfunction

	// DRAM model with read data valid alongside the strobe
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			dram_next <= 1'b0;
			dram_wait <= 0;
		end
		else if (dram_next)
			dram_next <= 1'b0;                    // one cycle strobe
		else if (dram_req)
		begin
			if (dram_wait == 0)
				dram_wait <= draw_delay();
			else if (dram_wait > 1)
				dram_wait <= dram_wait - 1;
			else
			begin
				dram_next <= 1'b1;
				dram_wait <= 0;
				if (dram_rnw)
					dram_rddata <= mem[dram_addr[11:0]];
				else
					mem[dram_addr[11:0]] = dram_wrdata;
			end
		end
	end

	// SD card model moving one byte per strobe
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			sd_stb  <= 1'b0;
			sd_wait <= 0;
		end
		else if (sd_stb)
			sd_stb <= 1'b0;
		else if (sd_req)
		begin
			if (sd_wait == 0)
				sd_wait <= draw_delay();
			else if (sd_wait > 1)
				sd_wait <= sd_wait - 1;
			else
			begin
				sd_stb  <= 1'b1;
				sd_wait <= 0;
				if (!sd_rnw)
					sd_sink.push_back(sd_wrdata);
				else if (sd_src.size() > 0)
					sd_rddata <= sd_src.pop_front();
				else
				begin
					other_errors++;
					$display("SD source queue empty on a read strobe");
				end
			end
		end
	end

	// IDE model moving one word per strobe
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			ide_stb  <= 1'b0;
			ide_wait <= 0;
		end
		else if (ide_stb)
			ide_stb <= 1'b0;
		else if (ide_req)
		begin
			if (ide_wait == 0)
				ide_wait <= draw_delay();
			else if (ide_wait > 1)
				ide_wait <= ide_wait - 1;
			else
			begin
				ide_stb  <= 1'b1;
				ide_wait <= 0;
				if (!ide_rnw)
					ide_sink.push_back(ide_wrdata);
				else if (ide_src.size() > 0)
					ide_rddata <= ide_src.pop_front();
				else
				begin
					other_errors++;
					$display("IDE source queue empty on a read strobe");
				end
			end
		end
	end

	task automatic check_word(input string name, input dma_word_t got, input dma_word_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	// AW and W together with bready left high
	task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
		output logic [1:0] resp);
		@(posedge clk);
		s_awaddr  <= addr;
		s_wdata   <= data;
		s_awvalid <= 1'b1;
		s_wvalid  <= 1'b1;
		do
			@(posedge clk);
		while (!(s_awready && s_wready));
		s_awvalid <= 1'b0;
		s_wvalid  <= 1'b0;
		while (!(s_bvalid && s_bready))
			@(posedge clk);
		resp = s_bresp;
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
		output logic [1:0] resp);
		@(posedge clk);
		s_araddr  <= addr;
		s_arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!s_arready);
		s_arvalid <= 1'b0;
		while (!(s_rvalid && s_rready))
			@(posedge clk);
		data = s_rdata;
		resp = s_rresp;
	endtask

	task automatic start_burst(input dram_addr_t src, input dram_addr_t dst,
		input burst_len_t len, input axil_data_t ctrl);
		logic [1:0] resp;
		axi_write(REG_SADDR, axil_data_t'(src), resp);
		check_resp("bresp SADDR", resp, RESP_OKAY);
		axi_write(REG_DADDR, axil_data_t'(dst), resp);
		check_resp("bresp DADDR", resp, RESP_OKAY);
		axi_write(REG_LEN, axil_data_t'(len), resp);
		check_resp("bresp LEN", resp, RESP_OKAY);
		axi_write(REG_CTRL, ctrl, resp);   // launch
		check_resp("bresp CTRL", resp, RESP_OKAY);
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (busy && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (busy)
		begin
			other_errors++;
			$display("burst still busy after %0d cycles", limit);
		end
	endtask

	task automatic regs_readback();
		axil_data_t rd;
		logic [1:0] resp;
		check_flag("busy", busy, 1'b0);
		axi_read(REG_STATUS, rd, resp);
		check_resp("rresp STATUS", resp, RESP_OKAY);
		check_word("STATUS lo", rd[15:0], 16'h0000);
		check_word("STATUS hi", rd[31:16], 16'h0000);
		axi_write(REG_SADDR, 32'hFFFF_F123, resp);
		axi_read(REG_SADDR, rd, resp);
		check_addr("SADDR", rd[20:0], 21'h1F_F123);   // masked to 21 bits
		check_word("SADDR upper", dma_word_t'(rd[31:21]), 16'h0000);
		axi_write(REG_DADDR, 32'h8000_0ABC, resp);
		axi_read(REG_DADDR, rd, resp);
		check_addr("DADDR", rd[20:0], 21'h00_0ABC);
		check_word("DADDR upper", dma_word_t'(rd[31:21]), 16'h0000);
		axi_write(REG_LEN, 32'hFFFF_FF5A, resp);
		axi_read(REG_LEN, rd, resp);
		check_word("LEN lo", rd[15:0], 16'h005A);
		check_word("LEN hi", rd[31:16], 16'h0000);
		axi_write(REG_STATUS, 32'h0000_01FF, resp);
		check_resp("bresp STATUS", resp, RESP_SLVERR);   // read only
		axi_read(5'h14, rd, resp);
		check_resp("rresp hole", resp, RESP_SLVERR);
		check_word("hole data", rd[15:0], 16'h0000);
	endtask

	task automatic ram_copy();
		axil_data_t rd;
		logic [1:0] resp;
		start_burst(21'd100, 21'd300, 8'd7, ctrl_word(DEV_RAM, 1'b0));
		wait_idle(2000);
		for (int k = 0; k < 8; k++)
		begin
			check_word($sformatf("mem[%0d]", 300 + k), mem[300 + k], fill_word(100 + k));
			check_word($sformatf("mem[%0d]", 100 + k), mem[100 + k], fill_word(100 + k));
		end
		check_word("mem[308]", mem[308], fill_word(308));   // nothing past the end
		check_flag("busy", busy, 1'b0);
		axi_read(REG_STATUS, rd, resp);
		check_flag("STATUS act", rd[STAT_ACT], 1'b0);
		check_word("STATUS lo", rd[15:0], 16'h0000);
	endtask

	task automatic sd_to_ram();
		sd_byte_t b [0:7];
		int r;
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			b[i] = r[7:0];
			sd_src.push_back(b[i]);
		end
		start_burst(21'd0, 21'd500, 8'd3, ctrl_word(DEV_SD, 1'b0));
		wait_idle(2000);
		for (int k = 0; k < 4; k++)   // first byte is the low half
			check_word($sformatf("mem[%0d]", 500 + k), mem[500 + k], {b[2*k+1], b[2*k]});
		check_word("SD bytes left", dma_word_t'(sd_src.size()), 16'd0);
	endtask

	task automatic ram_to_dev();
		ide_sink.delete();
		sd_sink.delete();
		start_burst(21'd700, 21'd0, 8'd4, ctrl_word(DEV_IDE, 1'b1));
		wait_idle(2000);
		check_word("IDE words", dma_word_t'(ide_sink.size()), 16'd5);
		for (int k = 0; k < 5 && k < ide_sink.size(); k++)
			check_word($sformatf("ide word %0d", k), ide_sink[k], fill_word(700 + k));
		start_burst(21'd800, 21'd0, 8'd2, ctrl_word(DEV_SD, 1'b1));
		wait_idle(2000);
		check_word("SD bytes", dma_word_t'(sd_sink.size()), 16'd6);
		for (int k = 0; k < 3 && 2 * k + 1 < sd_sink.size(); k++)
		begin
			check_word($sformatf("sd lo %0d", k), dma_word_t'(sd_sink[2*k]),
				dma_word_t'(fill_word(800 + k) & 16'h00FF));
			check_word($sformatf("sd hi %0d", k), dma_word_t'(sd_sink[2*k+1]),
				dma_word_t'(fill_word(800 + k) >> 8));
		end
	endtask

	task automatic write_lockout();
		axil_data_t rd;
		logic [1:0] resp;
		start_burst(21'd1000, 21'd1200, 8'd15, ctrl_word(DEV_RAM, 1'b0));
		check_flag("busy", busy, 1'b1);
		axi_write(REG_DADDR, 32'd1500, resp);
		check_resp("bresp DADDR locked", resp, RESP_SLVERR);
		axi_write(REG_CTRL, ctrl_word(DEV_IDE, 1'b1), resp);
		check_resp("bresp CTRL locked", resp, RESP_SLVERR);
		wait_idle(2000);
		for (int k = 0; k < 16; k++)
			check_word($sformatf("mem[%0d]", 1200 + k), mem[1200 + k], fill_word(1000 + k));
		axi_read(REG_DADDR, rd, resp);
		check_addr("DADDR", rd[20:0], 21'd1200);
	endtask

	task automatic backpressure();
		dma_word_t w [0:9];
		int r;
		@(posedge clk);
		s_bready  <= 1'b0;
		s_awaddr  <= REG_SADDR;
		s_wdata   <= 32'd1600;
		s_awvalid <= 1'b1;
		s_wvalid  <= 1'b1;
		do
			@(posedge clk);
		while (!(s_awready && s_wready));
		s_awvalid <= 1'b0;
		s_wvalid  <= 1'b0;
		repeat (10)
		begin
			@(posedge clk);
			check_flag("s_bvalid", s_bvalid, 1'b1);
			check_resp("s_bresp", s_bresp, RESP_OKAY);
		end
		s_bready <= 1'b1;
		@(posedge clk);   // response taken here
		// read side held the same way
		@(posedge clk);
		s_rready  <= 1'b0;
		s_araddr  <= REG_SADDR;
		s_arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!s_arready);
		s_arvalid <= 1'b0;
		repeat (10)
		begin
			@(posedge clk);
			check_flag("s_rvalid", s_rvalid, 1'b1);
			check_addr("s_rdata", s_rdata[20:0], 21'd1600);
			check_resp("s_rresp", s_rresp, RESP_OKAY);
		end
		s_rready <= 1'b1;
		@(posedge clk);
		delay_span = 10;
		for (int k = 0; k < 10; k++)
		begin
			r = $random(seed);
			w[k] = r[15:0];
			ide_src.push_back(w[k]);
		end
		start_burst(21'd1600, 21'd1700, 8'd9, ctrl_word(DEV_IDE, 1'b0));
		wait_idle(4000);
		delay_span = 3;
		for (int k = 0; k < 10; k++)
			check_word($sformatf("mem[%0d]", 1700 + k), mem[1700 + k], w[k]);
		check_word("mem[1699]", mem[1699], fill_word(1699));
		check_word("mem[1710]", mem[1710], fill_word(1710));
		check_word("IDE words left", dma_word_t'(ide_src.size()), 16'd0);
	endtask

	initial
	begin
		int total;
		rst_n     = 1'b0;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = 4'hF;
		s_wvalid  = 1'b0;
		s_bready  = 1'b1;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		regs_readback();
		ram_copy();
		sd_to_ram();
		ram_to_dev();
		write_lockout();
		backpressure();
		total = value_errors + other_errors + int'(zdma_top_inst.props_inst.fail_count);
		$display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
			zdma_top_inst.props_inst.fail_count);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- zdma.f
source/dma_types_pkg.sv
source/dma_regs_pkg.sv
source/dma_csr_axil.sv
source/dma_engine.sv
source/dma_dev_router.sv
source/zdma_top.sv
verif/zdma_properties.sv
verif/zdma_tb.sv

//--- Makefile
# Verilator simulation of the zdma testbench
VERILATOR ?= verilator
TOP       ?= zdma_tb
SEED      ?= 6646
FILELIST  ?= zdma.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
